// File: Bender.yml
package:
  name: kmac_absorb

export_include_dirs:
  - include

sources:
  # RTL in compile order
  - files:
      - verilog/kmac_absorb_pkg.sv
      - verilog/msg_unpacker.sv
      - verilog/msg_remasker.sv
      - verilog/state_absorber.sv
      - verilog/kmac_absorb_top.sv
  # Testbench
  - target: test
    files:
      - testbench/tb_kmac_absorb.sv

// File: include/kmac_absorb_params.svh
/*
  Width, depth and constant macros for the masked absorb front end
  Lane and chunk sizes, credit depth, LFSR seed, taps and mask permutation
*/

`ifndef KMAC_ABSORB_PARAMS_SVH
`define KMAC_ABSORB_PARAMS_SVH

`define KMAC_LANE_W     64                    // One lane word
`define KMAC_CHUNK_W    128                   // Two lanes per host chunk
`define KMAC_NUM_LANES  4                     // Lanes in the absorb state
`define KMAC_IDX_W      2                     // Lane index bits
`define KMAC_CREDITS    2                     // Chunk buffer entries
`define KMAC_PTR_W      1                     // Chunk buffer pointer bits
`define KMAC_CNT_W      2                     // Fill and credit counter bits

`define KMAC_LFSR_SEED  64'h5a3c_96e1_0f7b_d248
`define KMAC_LFSR_TAPS  64'hd800_0000_0000_0000 // x^64 + x^63 + x^61 + x^60 + 1

// Bit i of the mask takes LFSR bit PERM[i], element 63 first
`define KMAC_PERM_IDX_W 6
`define KMAC_MSG_PERM { \
  6'd38, 6'd1,  6'd28, 6'd55, 6'd18, 6'd45, 6'd8,  6'd35, \
  6'd62, 6'd25, 6'd52, 6'd15, 6'd42, 6'd5,  6'd32, 6'd59, \
  6'd22, 6'd49, 6'd12, 6'd39, 6'd2,  6'd29, 6'd56, 6'd19, \
  6'd46, 6'd9,  6'd36, 6'd63, 6'd26, 6'd53, 6'd16, 6'd43, \
  6'd6,  6'd33, 6'd60, 6'd23, 6'd50, 6'd13, 6'd40, 6'd3,  \
  6'd30, 6'd57, 6'd20, 6'd47, 6'd10, 6'd37, 6'd0,  6'd27, \
  6'd54, 6'd17, 6'd44, 6'd7,  6'd34, 6'd61, 6'd24, 6'd51, \
  6'd14, 6'd41, 6'd4,  6'd31, 6'd58, 6'd21, 6'd48, 6'd11  \
}

`endif

// File: project.f
+incdir+include
verilog/kmac_absorb_pkg.sv
verilog/msg_unpacker.sv
verilog/msg_remasker.sv
verilog/state_absorber.sv
verilog/kmac_absorb_top.sv
testbench/tb_kmac_absorb.sv

// File: testbench/kmac_absorb_input.txt
# Columns: CHUNK share0|RAND share1 last mask_en, OVERFLOW share0 share1, RESEED seed,
# START, EXPECT lane0 lane1 lane2 lane3 (recombined); RAND puts the plain chunk in share1
START
# Masked message, four lanes
CHUNK RAND 0123456789abcdeffedcba9876543210 0 1
CHUNK RAND 0f0f0f0f0f0f0f0fa5a5a5a5a5a5a5a5 1 1
EXPECT fedcba9876543210 0123456789abcdef a5a5a5a5a5a5a5a5 0f0f0f0f0f0f0f0f
# Six lanes, the third chunk folds into slots 0 and 1
START
CHUNK RAND 10000000000000010000000000000003 0 1
CHUNK RAND 22222222222222223333333333333333 0 1
CHUNK RAND 00000000000000f00000000000000005 1 1
EXPECT 0000000000000006 10000000000000f1 3333333333333333 2222222222222222
# Masking off, explicit shares
START
CHUNK aaaaaaaaaaaaaaaa5555555555555555 0000000000000001ffffffffffffffff 1 0
EXPECT aaaaaaaaaaaaaaaa aaaaaaaaaaaaaaab 0000000000000000 0000000000000000
# Same message after a reseed, then after a zero seed
RESEED 0123456789abcdef
START
CHUNK RAND 0123456789abcdeffedcba9876543210 0 1
CHUNK RAND 0f0f0f0f0f0f0f0fa5a5a5a5a5a5a5a5 1 1
EXPECT fedcba9876543210 0123456789abcdef a5a5a5a5a5a5a5a5 0f0f0f0f0f0f0f0f
RESEED 0000000000000000
START
CHUNK RAND 0123456789abcdeffedcba9876543210 0 1
CHUNK RAND 0f0f0f0f0f0f0f0fa5a5a5a5a5a5a5a5 1 1
EXPECT fedcba9876543210 0123456789abcdef a5a5a5a5a5a5a5a5 0f0f0f0f0f0f0f0f
# Two chunks fill the buffer, the third is dropped
START
CHUNK RAND 00000000000000070000000000000009 0 1
CHUNK RAND 8000000000000000000000000000000c 1 1
OVERFLOW ffffffffffffffffffffffffffffffff 123456789abcdef00fedcba987654321
EXPECT 0000000000000009 0000000000000007 000000000000000c 8000000000000000
# Restart with the error still set
START
CHUNK 11111111111111112222222222222222 33333333333333334444444444444444 1 1
EXPECT 6666666666666666 2222222222222222 0000000000000000 0000000000000000

// File: testbench/tb_kmac_absorb.sv
/*
  Testbench for the masked absorb front end
  File-driven chunks, reseeds, restarts and overflow, host credit tracking
  Recombined state, share0 pass-through, credit count and err_o checks
*/

`timescale 1ns/100ps
`include "kmac_absorb_params.svh"

module tb_kmac_absorb;
  import kmac_absorb_pkg::*;

  localparam int TIMEOUT_CYC = 200;               // Cycles allowed per wait
  localparam int TOK_W       = 8*40;              // Token buffer, 40 chars

  logic                     clk_i;
  logic                     rst_i;
  logic                     chunk_valid_i;
  chunk_shares_t            chunk_i;
  logic                     chunk_credit_o;
  logic                     mask_en_i;
  logic                     reseed_valid_i;
  lane_t                    reseed_i;
  logic                     start_i;
  logic                     state_valid_o;
  absorb_state_t            state_o;
  logic                     err_o;

  int                       credits;              // Host side chunk credits
  lane_t                    exp_plain [`KMAC_NUM_LANES]; // Recombined sum per slot
  lane_t                    exp_sh0 [`KMAC_NUM_LANES];   // Share0 sum per slot
  logic                     all_clear;            // Whole message unmasked
  int                       slot_ptr;             // Next lane slot
  logic                     exp_err;

  kmac_absorb_top u_kmac_absorb_top (
    .clk_i, .rst_i, .chunk_valid_i, .chunk_i, .chunk_credit_o, .mask_en_i,
    .reseed_valid_i, .reseed_i, .start_i, .state_valid_o, .state_o, .err_o
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;                   // 40 ns period
  end

  ////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  function automatic logic [`KMAC_CHUNK_W-1:0] rand_chunk();
    rand_chunk = {$urandom, $urandom, $urandom, $urandom};
  endfunction

  task automatic clear_model();
    for (int i = 0; i < `KMAC_NUM_LANES; i++) begin
      exp_plain[i] = '0;
      exp_sh0[i]   = '0;
    end
    all_clear = 1'b1;
  endtask

  // Low lane first, slot wraps modulo 4, back to 0 after last
  task automatic absorb_model(input logic [`KMAC_CHUNK_W-1:0] s0, s1, input logic last,
                              input logic mask);
    logic [`KMAC_CHUNK_W-1:0] plain;
    plain = s0 ^ s1;
    exp_plain[slot_ptr] = exp_plain[slot_ptr] ^ plain[`KMAC_LANE_W-1:0];
    exp_sh0[slot_ptr]   = exp_sh0[slot_ptr] ^ s0[`KMAC_LANE_W-1:0];
    slot_ptr = (slot_ptr + 1) % `KMAC_NUM_LANES;
    exp_plain[slot_ptr] = exp_plain[slot_ptr] ^ plain[`KMAC_CHUNK_W-1:`KMAC_LANE_W];
    exp_sh0[slot_ptr]   = exp_sh0[slot_ptr] ^ s0[`KMAC_CHUNK_W-1:`KMAC_LANE_W];
    slot_ptr = last ? 0 : (slot_ptr + 1) % `KMAC_NUM_LANES;
    if (mask) all_clear = 1'b0;
  endtask

  task automatic reset_dut();
    rst_i = 1'b1;
    repeat (2) @(posedge clk_i);
    #2;
    assert (!chunk_credit_o && !state_valid_o && !err_o && state_o == '0)
      else fail_now("Outputs not cleared while reset is held");
    rst_i     = 1'b0;
    credits   = `KMAC_CREDITS;                     // Host starts with full buffer
    slot_ptr  = 0;
    exp_err   = 1'b0;
    clear_model();
  endtask

  task automatic wait_credit();
    int cyc;
    cyc = 0;
    while (credits == 0) begin
      if (cyc >= TIMEOUT_CYC) begin
        fail_now("Timed out waiting for a chunk credit");
      end else begin
        @(posedge clk_i);
        #2;
        cyc++;
      end
    end
  endtask

  task automatic send_chunk(input logic [`KMAC_CHUNK_W-1:0] s0, s1, input logic last,
                            input logic mask);
    wait_credit();
    chunk_i.share0 = s0;
    chunk_i.share1 = s1;
    chunk_i.last   = last;
    mask_en_i      = mask;                        // Level, held until next chunk
    chunk_valid_i  = 1'b1;
    credits        = credits - 1;
    absorb_model(s0, s1, last, mask);
    @(posedge clk_i);
    #2;
    chunk_valid_i  = 1'b0;
  endtask

  // Dropped chunk, no model update and no credit spent
  task automatic send_overflow(input logic [`KMAC_CHUNK_W-1:0] s0, s1);
    assert (credits == 0)
      else fail_now("Overflow chunk requested while the host still holds a credit");
    chunk_i.share0 = s0;
    chunk_i.share1 = s1;
    chunk_i.last   = 1'b0;
    chunk_valid_i  = 1'b1;
    @(posedge clk_i);
    #2;
    chunk_valid_i  = 1'b0;
    exp_err        = 1'b1;
    assert (err_o == 1'b1)
      else fail_now($sformatf("MISMATCH err_o expected 0x1 got 0x%h", err_o));
  endtask

  task automatic pulse_start();
    start_i = 1'b1;
    @(posedge clk_i);
    #2;
    start_i = 1'b0;
    assert (state_valid_o == 1'b0)
      else fail_now($sformatf("MISMATCH state_valid_o expected 0x0 got 0x%h", state_valid_o));
    assert (state_o == '0)
      else fail_now($sformatf("MISMATCH state_o expected 0x0 got 0x%h", state_o));
    clear_model();
  endtask

  task automatic load_seed(input lane_t seed);
    reseed_i       = seed;
    reseed_valid_i = 1'b1;
    @(posedge clk_i);
    #2;
    reseed_valid_i = 1'b0;
  endtask

  task automatic check_state(input lane_t e0, e1, e2, e3);
    lane_t exp_file [`KMAC_NUM_LANES];
    lane_t got;
    int    cyc;
    int    i;
    exp_file[0] = e0;
    exp_file[1] = e1;
    exp_file[2] = e2;
    exp_file[3] = e3;
    cyc = 0;
    while (!state_valid_o) begin
      if (cyc >= TIMEOUT_CYC) begin
        fail_now("Timed out waiting for state_valid_o");
      end else begin
        @(posedge clk_i);
        #2;
        cyc++;
      end
    end
    for (i = 0; i < `KMAC_NUM_LANES; i++) begin
      got = state_o.share0[i] ^ state_o.share1[i];
      assert (got == exp_file[i])
        else fail_now($sformatf("MISMATCH state_o lane %0d expected 0x%h got 0x%h",
                                i, exp_file[i], got));
      assert (exp_file[i] == exp_plain[i])
        else fail_now($sformatf("Input file expects lane %0d differently from the chunk sum", i));
      if (all_clear) begin
        assert (state_o.share0[i] == exp_sh0[i])
          else fail_now($sformatf("MISMATCH state_o.share0 lane %0d expected 0x%h got 0x%h",
                                  i, exp_sh0[i], state_o.share0[i]));
      end
    end
    assert (credits == `KMAC_CREDITS)              // Every entry came back
      else fail_now($sformatf("MISMATCH chunk_credit_o count expected 0x%h got 0x%h",
                              `KMAC_CREDITS, credits));
    assert (err_o == exp_err)
      else fail_now($sformatf("MISMATCH err_o expected 0x%h got 0x%h", exp_err, err_o));
  endtask

  // Credit returns sampled mid-cycle
  always @(negedge clk_i) begin
    if (!rst_i && chunk_credit_o) begin
      credits = credits + 1;
      assert (credits <= `KMAC_CREDITS)
        else fail_now($sformatf("MISMATCH chunk_credit_o count expected 0x%h got 0x%h",
                                `KMAC_CREDITS, credits));
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////

  initial begin
    int                       fd;
    int                       n;
    int unsigned              seed_val;
    logic                     done;
    logic [8*12-1:0]          cmd;
    logic [TOK_W-1:0]         tok0;
    logic [TOK_W-1:0]         tok1;
    logic [8*200-1:0]         skip;
    logic                     last_bit;
    logic                     mask_bit;
    logic [`KMAC_CHUNK_W-1:0] s0;
    logic [`KMAC_CHUNK_W-1:0] s1;
    lane_t                    e0, e1, e2, e3;
    seed_val       = 32'hfabc_d8d7;
    n              = $urandom(seed_val);          // Seed once
    rst_i          = 1'b1;
    chunk_valid_i  = 1'b0;
    chunk_i        = '0;
    mask_en_i      = 1'b0;
    reseed_valid_i = 1'b0;
    reseed_i       = '0;
    start_i        = 1'b0;
    reset_dut();
    fd = $fopen("testbench/kmac_absorb_input.txt", "r");
    if (fd == 0) begin
      fail_now("Cannot open testbench/kmac_absorb_input.txt");
    end else begin
      done = 1'b0;
      while (!done) begin
        n = $fscanf(fd, "%s", cmd);
        if (n != 1) begin
          done = 1'b1;                            // End of file
        end else if (cmd == "#") begin
          n = $fgets(skip, fd);
        end else if (cmd == "CHUNK") begin
          n = $fscanf(fd, "%s %s %h %h", tok0, tok1, last_bit, mask_bit);
          n = $sscanf(tok1, "%h", s1);
          if (tok0 == "RAND") begin
            s0 = rand_chunk();
            s1 = s1 ^ s0;                         // Column held the plain chunk
          end else begin
            n = $sscanf(tok0, "%h", s0);
          end
          send_chunk(s0, s1, last_bit, mask_bit);
        end else if (cmd == "OVERFLOW") begin
          n = $fscanf(fd, "%h %h", s0, s1);
          send_overflow(s0, s1);
        end else if (cmd == "RESEED") begin
          n = $fscanf(fd, "%h", e0);
          load_seed(e0);
        end else if (cmd == "START") begin
          pulse_start();
        end else if (cmd == "EXPECT") begin
          n = $fscanf(fd, "%h %h %h %h", e0, e1, e2, e3);
          check_state(e0, e1, e2, e3);
        end else begin
          fail_now($sformatf("Unknown command %0s in the stimulus file", cmd));
        end
      end
      $fclose(fd);
      reset_dut();                                // Sticky error drops only here
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

// File: verilog/kmac_absorb_pkg.sv
/*
  Shared types of the masked absorb front end
  Lane word, lane index, mask permutation table
  Share-pair lane, share-pair chunk, lane beat, two-share absorb state
*/

`include "kmac_absorb_params.svh"

package kmac_absorb_pkg;

  //////////////////////////////////////////////////////////////////////
  // Scalar types
  //////////////////////////////////////////////////////////////////////

  typedef logic [`KMAC_LANE_W-1:0] lane_t;     // One 64-bit lane
  typedef logic [`KMAC_IDX_W-1:0]  lane_idx_t; // Lane slot in state

  // One LFSR bit index per mask bit
  typedef logic [`KMAC_LANE_W-1:0][`KMAC_PERM_IDX_W-1:0] msg_perm_t;

  //////////////////////////////////////////////////////////////////////
  // Share-carrying structs
  //////////////////////////////////////////////////////////////////////

  // Both shares of a single lane
  typedef struct packed {
    lane_t share0;
    lane_t share1;
  } lane_shares_t;

  // Host chunk, low lane in the low half
  typedef struct packed {
    logic [`KMAC_CHUNK_W-1:0] share0;
    logic [`KMAC_CHUNK_W-1:0] share1;
    logic                     last;   // Final chunk of message
  } chunk_shares_t;

  // Lane moving between the stages
  typedef struct packed {
    lane_shares_t shares;
    logic         last;   // Final lane of message
    lane_idx_t    idx;    // Target slot, modulo 4
  } lane_beat_t;

  // Absorbed state, recombines as share0 ^ share1
  typedef struct packed {
    lane_t [`KMAC_NUM_LANES-1:0] share0;
    lane_t [`KMAC_NUM_LANES-1:0] share1;
  } absorb_state_t;

endpackage

// File: verilog/kmac_absorb_top.sv
/*
  Masked absorb front end top level
  Chains unpacker, remasker and absorber over credit links
  Sticky error flag from buffer overflow
*/

`timescale 1ns/100ps
`include "kmac_absorb_params.svh"

module kmac_absorb_top (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic                           chunk_valid_i,
  input  kmac_absorb_pkg::chunk_shares_t chunk_i,
  output logic                           chunk_credit_o,
  input  logic                           mask_en_i,
  input  logic                           reseed_valid_i,
  input  logic [`KMAC_LANE_W-1:0]        reseed_i,
  input  logic                           start_i,
  output logic                           state_valid_o,
  output kmac_absorb_pkg::absorb_state_t state_o,
  output logic                           err_o
);
  import kmac_absorb_pkg::*;

  lane_beat_t unp_lane;        // Unpacker to remasker
  logic       unp_lane_valid;
  logic       rmk_credit;      // Remasker slot returned
  lane_beat_t rmk_lane;        // Remasker to absorber
  logic       rmk_lane_valid;
  logic       abs_credit;
  logic       overflow;
  logic       err_q;

  //////////////////////////////////////////////////////////////////////
  // Stages
  //////////////////////////////////////////////////////////////////////

  msg_unpacker u_msg_unpacker (
    .clk_i,
    .rst_i,
    .chunk_valid_i (chunk_valid_i),
    .chunk_i       (chunk_i),
    .chunk_credit_o(chunk_credit_o),
    .lane_valid_o  (unp_lane_valid),
    .lane_o        (unp_lane),
    .lane_credit_i (rmk_credit),
    .overflow_o    (overflow)
  );

  msg_remasker u_msg_remasker (
    .clk_i,
    .rst_i,
    .mask_en_i     (mask_en_i),
    .reseed_valid_i(reseed_valid_i),
    .reseed_i      (reseed_i),
    .lane_valid_i  (unp_lane_valid),
    .lane_i        (unp_lane),
    .lane_credit_o (rmk_credit),
    .lane_valid_o  (rmk_lane_valid),
    .lane_o        (rmk_lane),
    .lane_credit_i (abs_credit)
  );

  state_absorber u_state_absorber (
    .clk_i,
    .rst_i,
    .start_i      (start_i),
    .lane_valid_i (rmk_lane_valid),
    .lane_i       (rmk_lane),
    .lane_credit_o(abs_credit),
    .state_valid_o(state_valid_o),
    .state_o      (state_o)
  );

  // Error stays set until reset
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      err_q <= 1'b0;
    end else if (overflow) begin
      err_q <= 1'b1;
    end
  end

  assign err_o = err_q;

endmodule

// File: verilog/msg_remasker.sv
/*
  Lane re-masking stage
  64-bit Galois LFSR PRNG with host reseed
  Bitwise permuted mask XORed into both shares, one register stage
*/

`timescale 1ns/100ps
`include "kmac_absorb_params.svh"

module msg_remasker (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        mask_en_i,
  input  logic                        reseed_valid_i,
  input  logic [`KMAC_LANE_W-1:0]     reseed_i,
  input  logic                        lane_valid_i,
  input  kmac_absorb_pkg::lane_beat_t lane_i,
  output logic                        lane_credit_o,
  output logic                        lane_valid_o,
  output kmac_absorb_pkg::lane_beat_t lane_o,
  input  logic                        lane_credit_i
);
  import kmac_absorb_pkg::*;

  localparam lane_t     LFSR_SEED = `KMAC_LFSR_SEED;
  localparam lane_t     LFSR_TAPS = `KMAC_LFSR_TAPS;
  localparam msg_perm_t MSG_PERM  = `KMAC_MSG_PERM;

  lane_t      lfsr_q;
  lane_t      lfsr_step;  // Next LFSR value
  lane_t      seed_sel;   // Reseed value after zero guard
  lane_t      mask_perm;  // Permuted PRNG output
  lane_t      mask;       // Gated by mask_en_i
  lane_beat_t beat_q;
  logic       valid_q;

  //////////////////////////////////////////////////////////////////////
  // PRNG
  //////////////////////////////////////////////////////////////////////

  // Right-shift Galois form
  assign lfsr_step = {1'b0, lfsr_q[`KMAC_LANE_W-1:1]}
                   ^ ({`KMAC_LANE_W{lfsr_q[0]}} & LFSR_TAPS);

  assign seed_sel = (reseed_i == '0) ? LFSR_SEED : reseed_i; // All-zero would lock up

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      lfsr_q <= LFSR_SEED;
    end else if (reseed_valid_i) begin
      lfsr_q <= seed_sel;     // Reseed wins over stepping
    end else if (lane_valid_i) begin
      lfsr_q <= lfsr_step;    // One step per accepted beat
    end
  end

  // Shuffle bits so adjacent mask bits are not adjacent LFSR taps
  always_comb begin
    mask_perm = '0;
    for (int i = 0; i < `KMAC_LANE_W; i++) begin
      mask_perm[i] = lfsr_q[MSG_PERM[i]];
    end
  end

  assign mask = mask_perm & {`KMAC_LANE_W{mask_en_i}};

  //////////////////////////////////////////////////////////////////////
  // Re-mask register
  //////////////////////////////////////////////////////////////////////

  // Same mask on both shares keeps the recombined lane intact
  always_ff @(posedge clk_i) begin
    if (lane_valid_i) begin
      beat_q.shares.share0 <= lane_i.shares.share0 ^ mask;
      beat_q.shares.share1 <= lane_i.shares.share1 ^ mask;
      beat_q.last          <= lane_i.last;
      beat_q.idx           <= lane_i.idx;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= lane_valid_i | (valid_q & ~lane_credit_i); // Hold until consumed
    end
  end

  assign lane_valid_o  = valid_q;
  assign lane_o        = beat_q;
  assign lane_credit_o = valid_q & lane_credit_i; // Slot freed downstream

  // Zero guard on reseed keeps the PRNG out of its dead state
  a_lfsr_nonzero : assert property (@(posedge clk_i) disable iff (rst_i)
    lfsr_q != '0);

endmodule

// File: verilog/msg_unpacker.sv
/*
  Two-entry chunk buffer with lane splitter
  Emits low then high lane of each chunk under a single downstream credit
  Returns one upstream credit per freed entry and flags writes when full
*/

`timescale 1ns/100ps
`include "kmac_absorb_params.svh"

module msg_unpacker (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic                           chunk_valid_i,
  input  kmac_absorb_pkg::chunk_shares_t chunk_i,
  output logic                           chunk_credit_o,
  output logic                           lane_valid_o,
  output kmac_absorb_pkg::lane_beat_t    lane_o,
  input  logic                           lane_credit_i,
  output logic                           overflow_o
);
  import kmac_absorb_pkg::*;

  localparam logic [`KMAC_CNT_W-1:0] DEPTH = `KMAC_CREDITS;

  chunk_shares_t          mem_q [`KMAC_CREDITS]; // Chunk storage
  chunk_shares_t          head;                  // Oldest entry
  logic [`KMAC_PTR_W-1:0] wr_ptr_q;
  logic [`KMAC_PTR_W-1:0] rd_ptr_q;
  logic [`KMAC_CNT_W-1:0] count_q;               // Entries held
  logic [`KMAC_CNT_W-1:0] cred_q;                // Remasker credits
  logic                   half_q;                // 0 low lane, 1 high lane
  lane_idx_t              idx_q;
  lane_beat_t             lane_q;
  logic                   lane_valid_q;
  logic                   chunk_credit_q;
  logic                   inflight_q;            // Remasker slot still taken
  logic                   full;
  logic                   empty;
  logic                   wr_en;
  logic                   cred_avail;
  logic                   send;
  logic                   pop;

  assign full       = (count_q == DEPTH);
  assign empty      = (count_q == '0);
  assign wr_en      = chunk_valid_i & ~full;
  assign cred_avail = (cred_q != '0) | lane_credit_i; // Returning credit usable now
  assign send       = ~empty & cred_avail;
  assign pop        = send & half_q;                  // High lane frees entry
  assign head       = mem_q[rd_ptr_q];

  //////////////////////////////////////////////////////////////////////
  // Chunk buffer
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem_q[wr_ptr_q] <= chunk_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_en) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop)   rd_ptr_q <= rd_ptr_q + 1'b1;
      if (wr_en && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (!wr_en && pop) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Lane split and credit tracking
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cred_q         <= 'd1;       // Remasker holds one slot
      half_q         <= 1'b0;
      idx_q          <= '0;
      lane_valid_q   <= 1'b0;
      chunk_credit_q <= 1'b0;
    end else begin
      lane_valid_q   <= send;
      chunk_credit_q <= pop;       // Upstream entry freed
      if (send && !lane_credit_i) begin
        cred_q <= cred_q - 1'b1;
      end else if (!send && lane_credit_i) begin
        cred_q <= cred_q + 1'b1;
      end
      if (send) begin
        half_q <= ~half_q;
        // Restart slot count after message end
        idx_q  <= (pop && head.last) ? '0 : idx_q + 1'b1;
      end
    end
  end

  // Payload register, no reset needed
  always_ff @(posedge clk_i) begin
    if (send) begin
      lane_q.shares.share0 <= half_q ? head.share0[`KMAC_CHUNK_W-1:`KMAC_LANE_W]
                                     : head.share0[`KMAC_LANE_W-1:0];
      lane_q.shares.share1 <= half_q ? head.share1[`KMAC_CHUNK_W-1:`KMAC_LANE_W]
                                     : head.share1[`KMAC_LANE_W-1:0];
      lane_q.last          <= half_q & head.last; // Only on high lane
      lane_q.idx           <= idx_q;
    end
  end

  assign lane_valid_o   = lane_valid_q;
  assign lane_o         = lane_q;
  assign chunk_credit_o = chunk_credit_q;
  assign overflow_o     = chunk_valid_i & full;  // Chunk dropped

  // Link view of the remasker slot, taken by a lane, freed by its credit
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      inflight_q <= 1'b0;
    end else begin
      inflight_q <= lane_valid_o | (inflight_q & ~lane_credit_i);
    end
  end

  // Remasker never hands back more than it was given
  a_cred_max : assert property (@(posedge clk_i) disable iff (rst_i)
    cred_q <= 'd1);

  // A new lane only leaves once the previous one was credited back
  a_lane_has_cred : assert property (@(posedge clk_i) disable iff (rst_i)
    lane_valid_o |-> !inflight_q);

endmodule

// File: verilog/state_absorber.sv
/*
  Two-share absorb state
  XORs each share of an incoming lane into the slot given by its index
  Presents the state after the last lane until the next start pulse
*/

`timescale 1ns/100ps

module state_absorber (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          start_i,
  input  logic                          lane_valid_i,
  input  kmac_absorb_pkg::lane_beat_t   lane_i,
  output logic                          lane_credit_o,
  output logic                          state_valid_o,
  output kmac_absorb_pkg::absorb_state_t state_o
);
  import kmac_absorb_pkg::*;

  absorb_state_t state_q;
  absorb_state_t state_d;
  lane_idx_t     slot;      // Target lane of this beat
  logic          valid_q;
  logic          valid_d;

  assign slot = lane_i.idx; // Two bits wrap modulo 4

  //////////////////////////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = start_i ? '0 : state_q;   // Start clears before absorbing
    valid_d = start_i ? 1'b0 : valid_q;
    if (lane_valid_i) begin
      state_d.share0[slot] = state_d.share0[slot] ^ lane_i.shares.share0;
      state_d.share1[slot] = state_d.share1[slot] ^ lane_i.shares.share1;
      if (lane_i.last) begin
        valid_d = 1'b1;                 // Visible the cycle after
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= '0;                    // First message starts from zero
      valid_q <= 1'b0;
    end else begin
      state_q <= state_d;
      valid_q <= valid_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////////////////////////

  assign lane_credit_o = lane_valid_i;  // Always absorbs, credit same cycle
  assign state_valid_o = valid_q;
  assign state_o       = state_q;

  // Host waits for start before the next message reaches here
  a_no_beat_when_done : assert property (@(posedge clk_i) disable iff (rst_i)
    lane_valid_i |-> !state_valid_o);

endmodule
